// File: common/arm_isa_pkg.sv
package arm_isa_pkg;

	//////////////////////////////////////////////////
	// field widths and positions
	//////////////////////////////////////////////////
	localparam int INSTR_W         = 32;
	localparam int EXEC_CMD_W      = 4;
	localparam int SHIFT_OPERAND_W = 12;
	localparam int SIGNED_IMM_W    = 24;
	localparam int STATUS_W        = 4;

	localparam int I_BIT = 25; // immediate select.
	localparam int S_BIT = 20; // set flags, or L for memory ops.

	typedef logic [INSTR_W-1:0]         instr_t;
	typedef logic [1:0]                 mode_t;
	typedef logic [3:0]                 opcode_t;
	typedef logic [EXEC_CMD_W-1:0]      exec_cmd_t;
	typedef logic [SHIFT_OPERAND_W-1:0] shift_operand_t;
	typedef logic [SIGNED_IMM_W-1:0]    signed_imm_t;
	typedef logic [STATUS_W-1:0]        status_t; // n z c v.

	// condition field, top nibble of the instruction.
	typedef enum logic [3:0] {
		COND_EQ = 4'b0000,
		COND_NE = 4'b0001,
		COND_CS = 4'b0010,
		COND_CC = 4'b0011,
		COND_MI = 4'b0100,
		COND_PL = 4'b0101,
		COND_VS = 4'b0110,
		COND_VC = 4'b0111,
		COND_HI = 4'b1000,
		COND_LS = 4'b1001,
		COND_GE = 4'b1010,
		COND_LT = 4'b1011,
		COND_GT = 4'b1100,
		COND_LE = 4'b1101,
		COND_AL = 4'b1110
	} cond_e;

	localparam mode_t MODE_DP     = 2'd0;
	localparam mode_t MODE_MEM    = 2'd1;
	localparam mode_t MODE_BRANCH = 2'd2;

	//////////////////////////////////////////////////
	// data processing opcodes
	//////////////////////////////////////////////////
	localparam opcode_t OP_AND = 4'b0000;
	localparam opcode_t OP_EOR = 4'b0001;
	localparam opcode_t OP_SUB = 4'b0010;
	localparam opcode_t OP_ADD = 4'b0100;
	localparam opcode_t OP_ADC = 4'b0101;
	localparam opcode_t OP_SBC = 4'b0110;
	localparam opcode_t OP_TST = 4'b1000;
	localparam opcode_t OP_CMP = 4'b1010;
	localparam opcode_t OP_ORR = 4'b1100;
	localparam opcode_t OP_MOV = 4'b1101;
	localparam opcode_t OP_MVN = 4'b1111;

	// alu commands.
	localparam exec_cmd_t EXE_MOV = 4'b0001;
	localparam exec_cmd_t EXE_MVN = 4'b1001;
	localparam exec_cmd_t EXE_ADD = 4'b0010;
	localparam exec_cmd_t EXE_ADC = 4'b0011;
	localparam exec_cmd_t EXE_SUB = 4'b0100;
	localparam exec_cmd_t EXE_SBC = 4'b0101;
	localparam exec_cmd_t EXE_AND = 4'b0110;
	localparam exec_cmd_t EXE_ORR = 4'b0111;
	localparam exec_cmd_t EXE_EOR = 4'b1000;

endpackage

// File: common/id_stage_pkg.sv
package id_stage_pkg;

	localparam int WORD_W     = 32;
	localparam int PC_W       = 32;
	localparam int REG_ADDR_W = 4;
	localparam int NUM_REGS   = 16;

	typedef logic [WORD_W-1:0]     word_t;
	typedef logic [PC_W-1:0]       pc_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;

	//////////////////////////////////////////////////
	// control bits for execute, memory and write-back
	//////////////////////////////////////////////////
	typedef struct packed {
		arm_isa_pkg::exec_cmd_t exec_cmd;
		logic                   mem_read;
		logic                   mem_write;
		logic                   wb_en;
		logic                   status_write;
		logic                   branch_taken;
	} id_ctrl_t;

	// id/ex register contents.
	typedef struct packed {
		pc_t                         pc;
		id_ctrl_t                    ctrl;
		logic                        imm;
		word_t                       val_rn;
		word_t                       val_rm; // rd for a store.
		reg_addr_t                   dest;
		arm_isa_pkg::shift_operand_t shift_operand;
		arm_isa_pkg::signed_imm_t    signed_imm;
		arm_isa_pkg::status_t        status;
		reg_addr_t                   src1;
		reg_addr_t                   src2;
	} id_ex_t;

	// write-back port into the register file.
	typedef struct packed {
		logic      en;
		reg_addr_t addr;
		word_t     data;
	} wb_t;

endpackage

// File: decode/condition_check.sv
module condition_check (
	input  arm_isa_pkg::cond_e   cond,
	input  arm_isa_pkg::status_t status,
	output logic                 pass
);

	logic n;
	logic z;
	logic c;
	logic v;

	assign {n, z, c, v} = status;

	always_comb begin
		case (cond)
			arm_isa_pkg::COND_EQ: pass = z;
			arm_isa_pkg::COND_NE: pass = ~z;
			arm_isa_pkg::COND_CS: pass = c;
			arm_isa_pkg::COND_CC: pass = ~c;
			arm_isa_pkg::COND_MI: pass = n;
			arm_isa_pkg::COND_PL: pass = ~n;
			arm_isa_pkg::COND_VS: pass = v;
			arm_isa_pkg::COND_VC: pass = ~v;
			arm_isa_pkg::COND_HI: pass = c & ~z;
			arm_isa_pkg::COND_LS: pass = ~c | z;
			arm_isa_pkg::COND_GE: pass = (n == v);
			arm_isa_pkg::COND_LT: pass = (n != v);
			arm_isa_pkg::COND_GT: pass = ~z & (n == v);
			arm_isa_pkg::COND_LE: pass = z | (n != v);
			arm_isa_pkg::COND_AL: pass = 1'b1;
			default:              pass = 1'b0; // nv is not part of the subset.
		endcase
	end

endmodule

// File: decode/control_unit.sv
module control_unit (
	input  arm_isa_pkg::mode_t     mode,
	input  arm_isa_pkg::opcode_t   opcode,
	input  logic                   s_bit,
	input  logic                   load_bit,
	output id_stage_pkg::id_ctrl_t ctrl
);

	always_comb begin
		ctrl = '0;
		case (mode)
			//////////////////////////////////////////////////
			// data processing
			//////////////////////////////////////////////////
			arm_isa_pkg::MODE_DP: begin
				ctrl.wb_en        = 1'b1;
				ctrl.status_write = s_bit;
				case (opcode)
					arm_isa_pkg::OP_MOV: ctrl.exec_cmd = arm_isa_pkg::EXE_MOV;
					arm_isa_pkg::OP_MVN: ctrl.exec_cmd = arm_isa_pkg::EXE_MVN;
					arm_isa_pkg::OP_ADD: ctrl.exec_cmd = arm_isa_pkg::EXE_ADD;
					arm_isa_pkg::OP_ADC: ctrl.exec_cmd = arm_isa_pkg::EXE_ADC;
					arm_isa_pkg::OP_SUB: ctrl.exec_cmd = arm_isa_pkg::EXE_SUB;
					arm_isa_pkg::OP_SBC: ctrl.exec_cmd = arm_isa_pkg::EXE_SBC;
					arm_isa_pkg::OP_AND: ctrl.exec_cmd = arm_isa_pkg::EXE_AND;
					arm_isa_pkg::OP_ORR: ctrl.exec_cmd = arm_isa_pkg::EXE_ORR;
					arm_isa_pkg::OP_EOR: ctrl.exec_cmd = arm_isa_pkg::EXE_EOR;
					arm_isa_pkg::OP_CMP: begin
						// updates flags only and drops the result.
						ctrl.exec_cmd     = arm_isa_pkg::EXE_SUB;
						ctrl.wb_en        = 1'b0;
						ctrl.status_write = 1'b1;
					end
					arm_isa_pkg::OP_TST: begin
						ctrl.exec_cmd     = arm_isa_pkg::EXE_AND;
						ctrl.wb_en        = 1'b0;
						ctrl.status_write = 1'b1;
					end
					default: begin
						ctrl.wb_en        = 1'b0; // unused opcode does nothing.
						ctrl.status_write = 1'b0;
					end
				endcase
			end

			//////////////////////////////////////////////////
			// ldr / str
			//////////////////////////////////////////////////
			arm_isa_pkg::MODE_MEM: begin
				ctrl.exec_cmd = arm_isa_pkg::EXE_ADD; // base plus offset.
				if (load_bit) begin
					ctrl.mem_read = 1'b1;
					ctrl.wb_en    = 1'b1;
				end else begin
					ctrl.mem_write = 1'b1;
				end
			end

			arm_isa_pkg::MODE_BRANCH: begin
				ctrl.branch_taken = 1'b1;
			end

			default: begin
				ctrl = '0;
			end
		endcase
	end

endmodule

// File: decode/register_file.sv
module register_file (
	input  logic                    clk,
	input  logic                    rst_n,
	input  id_stage_pkg::wb_t       wb,
	input  id_stage_pkg::reg_addr_t rd_addr1,
	input  id_stage_pkg::reg_addr_t rd_addr2,
	output id_stage_pkg::word_t     rd_data1,
	output id_stage_pkg::word_t     rd_data2
);

	id_stage_pkg::word_t regs [id_stage_pkg::NUM_REGS];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < id_stage_pkg::NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.en) begin
			regs[wb.addr] <= wb.data;
		end
	end

	// write-through so decode sees a result retiring this cycle.
	always_comb begin
		if (wb.en && (wb.addr == rd_addr1))
			rd_data1 = wb.data;
		else
			rd_data1 = regs[rd_addr1];
	end

	always_comb begin
		if (wb.en && (wb.addr == rd_addr2))
			rd_data2 = wb.data;
		else
			rd_data2 = regs[rd_addr2];
	end

endmodule

// File: decode/id_stage.sv
module id_stage (
	input  logic                    clk,
	input  logic                    rst_n,
	input  id_stage_pkg::pc_t       pc,
	input  arm_isa_pkg::instr_t     instr,
	input  arm_isa_pkg::status_t    status,
	input  logic                    hazard,
	input  id_stage_pkg::wb_t       wb,
	output id_stage_pkg::id_ex_t    stage,
	output logic                    two_src,
	output logic                    ignore_hazard,
	output id_stage_pkg::reg_addr_t src1,
	output id_stage_pkg::reg_addr_t src2
);

	arm_isa_pkg::cond_e      cond;
	arm_isa_pkg::mode_t      mode;
	arm_isa_pkg::opcode_t    opcode;
	logic                    imm;
	logic                    s_bit; // also the load bit.
	id_stage_pkg::reg_addr_t rn;
	id_stage_pkg::reg_addr_t rd;
	id_stage_pkg::reg_addr_t rm;
	logic                    is_dp;
	logic                    is_str;
	logic                    cond_pass;
	logic                    bubble;
	id_stage_pkg::id_ctrl_t  ctrl_raw;
	id_stage_pkg::word_t     val_rn;
	id_stage_pkg::word_t     val_rm;

	//////////////////////////////////////////////////
	// instruction fields
	//////////////////////////////////////////////////
	assign cond   = arm_isa_pkg::cond_e'(instr[31:28]);
	assign mode   = instr[27:26];
	assign imm    = instr[arm_isa_pkg::I_BIT];
	assign opcode = instr[24:21];
	assign s_bit  = instr[arm_isa_pkg::S_BIT];
	assign rn     = instr[19:16];
	assign rd     = instr[15:12];
	assign rm     = instr[3:0];

	assign is_dp  = (mode == arm_isa_pkg::MODE_DP);
	assign is_str = (mode == arm_isa_pkg::MODE_MEM) && !s_bit;

	assign src1 = rn;
	assign src2 = is_str ? rd : rm; // store data comes from rd.

	assign two_src       = (is_dp && !imm) || is_str;
	assign ignore_hazard = (is_dp && ((opcode == arm_isa_pkg::OP_MOV) ||
		(opcode == arm_isa_pkg::OP_MVN))) || (mode == arm_isa_pkg::MODE_BRANCH);

	control_unit u_control_unit (
		.mode     (mode),
		.opcode   (opcode),
		.s_bit    (s_bit),
		.load_bit (s_bit),
		.ctrl     (ctrl_raw)
	);

	condition_check u_condition_check (
		.cond   (cond),
		.status (status),
		.pass   (cond_pass)
	);

	register_file u_register_file (
		.clk      (clk),
		.rst_n    (rst_n),
		.wb       (wb),
		.rd_addr1 (src1),
		.rd_addr2 (src2),
		.rd_data1 (val_rn),
		.rd_data2 (val_rm)
	);

	assign bubble = hazard || !cond_pass;

	always_comb begin
		stage               = '0;
		stage.pc            = pc;
		stage.ctrl          = bubble ? '0 : ctrl_raw; // data fields still pass.
		stage.imm           = bubble ? 1'b0 : imm;
		stage.val_rn        = val_rn;
		stage.val_rm        = val_rm;
		stage.dest          = rd;
		stage.shift_operand = instr[11:0];
		stage.signed_imm    = instr[23:0];
		stage.status        = status;
		stage.src1          = src1;
		stage.src2          = src2;
	end

endmodule

// File: hdl/id_ex_reg.sv
module id_ex_reg (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 flush,
	input  id_stage_pkg::id_ex_t d,
	output id_stage_pkg::id_ex_t q
);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			q <= '0;
		end else if (flush) begin
			q <= '0; // flush wins over new data.
		end else begin
			q <= d;
		end
	end

endmodule

// File: hdl/id_stage_top.sv
module id_stage_top (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    flush,
	input  logic                    hazard,
	input  id_stage_pkg::pc_t       pc,
	input  arm_isa_pkg::instr_t     instr,
	input  arm_isa_pkg::status_t    status,
	input  id_stage_pkg::wb_t       wb,
	output id_stage_pkg::id_ex_t    stage_out,
	output logic                    two_src,
	output logic                    ignore_hazard,
	output id_stage_pkg::reg_addr_t src1,
	output id_stage_pkg::reg_addr_t src2
);

	id_stage_pkg::id_ex_t stage_d;

	id_stage u_id_stage (
		.clk           (clk),
		.rst_n         (rst_n),
		.pc            (pc),
		.instr         (instr),
		.status        (status),
		.hazard        (hazard),
		.wb            (wb),
		.stage         (stage_d),
		.two_src       (two_src),
		.ignore_hazard (ignore_hazard),
		.src1          (src1),
		.src2          (src2)
	);

	id_ex_reg u_id_ex_reg (
		.clk   (clk),
		.rst_n (rst_n),
		.flush (flush),
		.d     (stage_d),
		.q     (stage_out)
	);

endmodule

// File: tb/tb_clock.sv
module tb_clock #(
	parameter int PERIOD       = 20,
	parameter int RESET_CYCLES = 10
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	initial begin
		rst_n <= 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1; // released on an edge so the flops see it next cycle.
	end

endmodule

// File: tb/id_stage_tb.sv
module id_stage_tb;

	localparam int CLK_PERIOD      = 20;
	localparam int RESET_CYCLES    = 10;
	localparam int NUM_ROWS        = 21;
	localparam int WATCHDOG_CYCLES = NUM_ROWS + 20;
	localparam int SEED            = 85;

	localparam id_stage_pkg::wb_t NO_WB = '0;

	// one table row holds the stimulus and then the expected values.
	typedef struct {
		arm_isa_pkg::instr_t     instr;
		arm_isa_pkg::status_t    status;
		logic                    hazard;
		logic                    flush;
		id_stage_pkg::wb_t       wb;
		id_stage_pkg::id_ctrl_t  exp_ctrl;
		logic                    exp_imm;
		id_stage_pkg::reg_addr_t exp_dest;
		id_stage_pkg::reg_addr_t exp_src1;
		id_stage_pkg::reg_addr_t exp_src2;
		logic [1:0]              exp_report; // two_src, ignore_hazard.
	} row_t;

	logic                    clk;
	logic                    rst_n;
	logic                    flush;
	logic                    hazard;
	id_stage_pkg::pc_t       pc;
	arm_isa_pkg::instr_t     instr;
	arm_isa_pkg::status_t    status;
	id_stage_pkg::wb_t       wb;
	id_stage_pkg::id_ex_t    stage_out;
	logic                    two_src;
	logic                    ignore_hazard;
	id_stage_pkg::reg_addr_t src1;
	id_stage_pkg::reg_addr_t src2;

	row_t                rows [NUM_ROWS];
	int                  n_rows;
	id_stage_pkg::word_t shadow [16]; // register contents as the writes imply.
	id_stage_pkg::word_t exp_rn [NUM_ROWS];
	id_stage_pkg::word_t exp_rm [NUM_ROWS];
	id_stage_pkg::pc_t   exp_pc [NUM_ROWS];

	tb_clock #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) u_clock (
		.clk   (clk),
		.rst_n (rst_n)
	);

	id_stage_top dut (
		.clk           (clk),
		.rst_n         (rst_n),
		.flush         (flush),
		.hazard        (hazard),
		.pc            (pc),
		.instr         (instr),
		.status        (status),
		.wb            (wb),
		.stage_out     (stage_out),
		.two_src       (two_src),
		.ignore_hazard (ignore_hazard),
		.src1          (src1),
		.src2          (src2)
	);

	//////////////////////////////////////////////////
	// instruction encoders
	//////////////////////////////////////////////////
	function automatic arm_isa_pkg::instr_t dp_instr(input arm_isa_pkg::cond_e cond,
		input logic imm_bit, input arm_isa_pkg::opcode_t op, input logic s,
		input logic [3:0] rn, input logic [3:0] rd, input logic [11:0] operand);
		return {cond, arm_isa_pkg::MODE_DP, imm_bit, op, s, rn, rd, operand};
	endfunction

	function automatic arm_isa_pkg::instr_t mem_instr(input arm_isa_pkg::cond_e cond,
		input logic load, input logic [3:0] rn, input logic [3:0] rd,
		input logic [11:0] offset);
		return {cond, arm_isa_pkg::MODE_MEM, 1'b0, 4'b1100, load, rn, rd, offset};
	endfunction

	function automatic arm_isa_pkg::instr_t branch_instr(input arm_isa_pkg::cond_e cond,
		input logic [23:0] offset);
		return {cond, arm_isa_pkg::MODE_BRANCH, 2'b00, offset};
	endfunction

	function automatic id_stage_pkg::wb_t write_port(input logic [3:0] addr,
		input id_stage_pkg::word_t data);
		id_stage_pkg::wb_t w;
		w.en   = 1'b1;
		w.addr = addr;
		w.data = data;
		return w;
	endfunction

	// bits are mem_read, mem_write, wb_en, status_write, branch_taken.
	task automatic add_row(
		input arm_isa_pkg::instr_t     instr_w,
		input arm_isa_pkg::status_t    flags,
		input logic [1:0]              hz_fl,
		input id_stage_pkg::wb_t       wb_w,
		input arm_isa_pkg::exec_cmd_t  cmd,
		input logic [4:0]              bits,
		input logic                    imm,
		input id_stage_pkg::reg_addr_t dest,
		input id_stage_pkg::reg_addr_t s1,
		input id_stage_pkg::reg_addr_t s2,
		input logic [1:0]              report
	);
		row_t r;
		r.instr                 = instr_w;
		r.status                = flags;
		r.hazard                = hz_fl[1];
		r.flush                 = hz_fl[0];
		r.wb                    = wb_w;
		r.exp_ctrl.exec_cmd     = cmd;
		r.exp_ctrl.mem_read     = bits[4];
		r.exp_ctrl.mem_write    = bits[3];
		r.exp_ctrl.wb_en        = bits[2];
		r.exp_ctrl.status_write = bits[1];
		r.exp_ctrl.branch_taken = bits[0];
		r.exp_imm               = imm;
		r.exp_dest              = dest;
		r.exp_src1              = s1;
		r.exp_src2              = s2;
		r.exp_report            = report;
		if (n_rows < NUM_ROWS)
			rows[n_rows] = r;
		n_rows++;
	endtask

	//////////////////////////////////////////////////
	// stimulus table
	//////////////////////////////////////////////////
	task automatic build_table();
		id_stage_pkg::word_t d [5];
		for (int k = 0; k < 5; k++)
			d[k] = $urandom;
		n_rows = 0;
		add_row(dp_instr(arm_isa_pkg::COND_AL, 1'b1, arm_isa_pkg::OP_MOV, 1'b0, 4'd0, 4'd0,
			12'h005), 4'b0000, 2'b00, NO_WB,
			arm_isa_pkg::EXE_MOV, 5'b00100, 1'b1, 4'd0, 4'd0, 4'd5, 2'b01);
		add_row(dp_instr(arm_isa_pkg::COND_AL, 1'b0, arm_isa_pkg::OP_ADC, 1'b0, 4'd1, 4'd4,
			12'h002), 4'b0000, 2'b00, NO_WB,
			arm_isa_pkg::EXE_ADC, 5'b00100, 1'b0, 4'd4, 4'd1, 4'd2, 2'b10);
		add_row(dp_instr(arm_isa_pkg::COND_AL, 1'b0, arm_isa_pkg::OP_ADD, 1'b1, 4'd1, 4'd6,
			12'h003), 4'b0000, 2'b00, write_port(4'd1, d[0]),
			arm_isa_pkg::EXE_ADD, 5'b00110, 1'b0, 4'd6, 4'd1, 4'd3, 2'b10);
		add_row(dp_instr(arm_isa_pkg::COND_AL, 1'b0, arm_isa_pkg::OP_AND, 1'b0, 4'd2, 4'd7,
			12'h001), 4'b0000, 2'b00, write_port(4'd2, d[1]),
			arm_isa_pkg::EXE_AND, 5'b00100, 1'b0, 4'd7, 4'd2, 4'd1, 2'b10);
		add_row(dp_instr(arm_isa_pkg::COND_AL, 1'b0, arm_isa_pkg::OP_CMP, 1'b1, 4'd3, 4'd0,
			12'h002), 4'b0000, 2'b00, write_port(4'd3, d[2]),
			arm_isa_pkg::EXE_SUB, 5'b00010, 1'b0, 4'd0, 4'd3, 4'd2, 2'b10);
		add_row(mem_instr(arm_isa_pkg::COND_AL, 1'b1, 4'd1, 4'd8, 12'h00C),
			4'b0000, 2'b00, write_port(4'd5, d[3]),
			arm_isa_pkg::EXE_ADD, 5'b10100, 1'b0, 4'd8, 4'd1, 4'd12, 2'b00);
		add_row(mem_instr(arm_isa_pkg::COND_AL, 1'b0, 4'd2, 4'd5, 12'h008),
			4'b0000, 2'b00, NO_WB,
			arm_isa_pkg::EXE_ADD, 5'b01000, 1'b0, 4'd5, 4'd2, 4'd5, 2'b10);
		add_row(branch_instr(arm_isa_pkg::COND_AL, 24'h012345), 4'b0000, 2'b00, NO_WB,
			4'h0, 5'b00001, 1'b0, 4'd2, 4'd1, 4'd5, 2'b01);
		// eq with z clear, then with z set.
		add_row(dp_instr(arm_isa_pkg::COND_EQ, 1'b0, arm_isa_pkg::OP_ADD, 1'b0, 4'd1, 4'd9,
			12'h002), 4'b0000, 2'b00, NO_WB,
			4'h0, 5'b00000, 1'b0, 4'd9, 4'd1, 4'd2, 2'b10);
		add_row(dp_instr(arm_isa_pkg::COND_EQ, 1'b0, arm_isa_pkg::OP_ADD, 1'b0, 4'd1, 4'd9,
			12'h002), 4'b0100, 2'b00, NO_WB,
			arm_isa_pkg::EXE_ADD, 5'b00100, 1'b0, 4'd9, 4'd1, 4'd2, 2'b10);
		add_row(dp_instr(arm_isa_pkg::COND_GE, 1'b1, arm_isa_pkg::OP_ORR, 1'b0, 4'd3, 4'd10,
			12'h0FF), 4'b1000, 2'b00, NO_WB,
			4'h0, 5'b00000, 1'b0, 4'd10, 4'd3, 4'd15, 2'b00);
		add_row(dp_instr(arm_isa_pkg::COND_HI, 1'b0, arm_isa_pkg::OP_EOR, 1'b0, 4'd1, 4'd11,
			12'h002), 4'b0010, 2'b00, NO_WB,
			arm_isa_pkg::EXE_EOR, 5'b00100, 1'b0, 4'd11, 4'd1, 4'd2, 2'b10);
		add_row(dp_instr(arm_isa_pkg::COND_LS, 1'b1, arm_isa_pkg::OP_MVN, 1'b0, 4'd0, 4'd12,
			12'h001), 4'b0010, 2'b00, NO_WB,
			4'h0, 5'b00000, 1'b0, 4'd12, 4'd0, 4'd1, 2'b01);
		// hazard bubble, then flush.
		add_row(dp_instr(arm_isa_pkg::COND_AL, 1'b0, arm_isa_pkg::OP_AND, 1'b0, 4'd1, 4'd4,
			12'h002), 4'b0000, 2'b10, NO_WB,
			4'h0, 5'b00000, 1'b0, 4'd4, 4'd1, 4'd2, 2'b10);
		add_row(dp_instr(arm_isa_pkg::COND_AL, 1'b0, arm_isa_pkg::OP_ADC, 1'b0, 4'd1, 4'd4,
			12'h002), 4'b0000, 2'b01, NO_WB,
			arm_isa_pkg::EXE_ADC, 5'b00100, 1'b0, 4'd4, 4'd1, 4'd2, 2'b10);
		add_row(dp_instr(arm_isa_pkg::COND_AL, 1'b0, arm_isa_pkg::OP_SBC, 1'b0, 4'd2, 4'd4,
			12'h003), 4'b0000, 2'b00, NO_WB,
			arm_isa_pkg::EXE_SBC, 5'b00100, 1'b0, 4'd4, 4'd2, 4'd3, 2'b10);
		add_row(dp_instr(arm_isa_pkg::COND_AL, 1'b1, arm_isa_pkg::OP_TST, 1'b1, 4'd1, 4'd0,
			12'h003), 4'b0000, 2'b00, NO_WB,
			arm_isa_pkg::EXE_AND, 5'b00010, 1'b1, 4'd0, 4'd1, 4'd3, 2'b00);
		add_row(dp_instr(arm_isa_pkg::COND_AL, 1'b0, arm_isa_pkg::OP_MVN, 1'b0, 4'd0, 4'd13,
			12'h003), 4'b0000, 2'b00, NO_WB,
			arm_isa_pkg::EXE_MVN, 5'b00100, 1'b0, 4'd13, 4'd0, 4'd3, 2'b11);
		add_row(dp_instr(arm_isa_pkg::COND_AL, 1'b0, arm_isa_pkg::OP_ORR, 1'b0, 4'd1, 4'd14,
			12'h001), 4'b0000, 2'b00, write_port(4'd1, d[4]),
			arm_isa_pkg::EXE_ORR, 5'b00100, 1'b0, 4'd14, 4'd1, 4'd1, 2'b10);
		add_row(dp_instr(arm_isa_pkg::COND_GT, 1'b0, arm_isa_pkg::OP_SUB, 1'b0, 4'd1, 4'd2,
			12'h003), 4'b1001, 2'b00, NO_WB,
			arm_isa_pkg::EXE_SUB, 5'b00100, 1'b0, 4'd2, 4'd1, 4'd3, 2'b10);
		add_row(mem_instr(arm_isa_pkg::COND_NE, 1'b0, 4'd1, 4'd3, 12'h000),
			4'b0100, 2'b00, NO_WB,
			4'h0, 5'b00000, 1'b0, 4'd3, 4'd1, 4'd3, 2'b10);
		if (n_rows != NUM_ROWS) begin
			$display("SIMULATION FAILED");
			$fatal(1, "stimulus table holds %0d rows instead of %0d", n_rows, NUM_ROWS);
		end
	endtask

	task automatic check_value(input logic [191:0] actual, input logic [191:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("SIMULATION FAILED");
			$fatal(1, "[FAIL] t=%0t %s: got %0h, expected %0h", $time, what, actual, expected);
		end
	endtask

	//////////////////////////////////////////////////
	// drive and check
	//////////////////////////////////////////////////
	task automatic drive_row(input int i);
		id_stage_pkg::reg_addr_t a1;
		id_stage_pkg::reg_addr_t a2;
		a1 = rows[i].exp_src1;
		a2 = rows[i].exp_src2;
		// a write in the same cycle shows up on the read.
		exp_rn[i] = (rows[i].wb.en && rows[i].wb.addr == a1) ? rows[i].wb.data : shadow[a1];
		exp_rm[i] = (rows[i].wb.en && rows[i].wb.addr == a2) ? rows[i].wb.data : shadow[a2];
		if (rows[i].wb.en)
			shadow[rows[i].wb.addr] = rows[i].wb.data;
		exp_pc[i] = 32'h0000_1000 + 32'(i) * 32'd4;
		pc     <= exp_pc[i];
		instr  <= rows[i].instr;
		status <= rows[i].status;
		hazard <= rows[i].hazard;
		flush  <= rows[i].flush;
		wb     <= rows[i].wb;
	endtask

	task automatic drive_idle();
		pc     <= '0;
		instr  <= '0;
		status <= '0;
		hazard <= 1'b0;
		flush  <= 1'b0;
		wb     <= NO_WB;
	endtask

	task automatic check_report(input int i);
		string tag;
		tag = $sformatf("row %0d", i);
		check_value(192'(two_src), 192'(rows[i].exp_report[1]), {tag, " two_src"});
		check_value(192'(ignore_hazard), 192'(rows[i].exp_report[0]), {tag, " ignore_hazard"});
		check_value(192'(src1), 192'(rows[i].exp_src1), {tag, " src1"});
		check_value(192'(src2), 192'(rows[i].exp_src2), {tag, " src2"});
	endtask

	task automatic check_stage(input int i);
		string tag;
		tag = $sformatf("row %0d", i);
		if (rows[i].flush) begin
			check_value(192'(stage_out), 192'(0), {tag, " flushed stage_out"});
		end else begin
			check_value(192'(stage_out.ctrl), 192'(rows[i].exp_ctrl), {tag, " ctrl"});
			check_value(192'(stage_out.imm), 192'(rows[i].exp_imm), {tag, " imm"});
			check_value(192'(stage_out.dest), 192'(rows[i].exp_dest), {tag, " dest"});
			check_value(192'(stage_out.pc), 192'(exp_pc[i]), {tag, " pc"});
			check_value(192'(stage_out.status), 192'(rows[i].status), {tag, " status"});
			check_value(192'(stage_out.val_rn), 192'(exp_rn[i]), {tag, " val_rn"});
			check_value(192'(stage_out.val_rm), 192'(exp_rm[i]), {tag, " val_rm"});
			check_value(192'(stage_out.src1), 192'(rows[i].exp_src1), {tag, " stage src1"});
			check_value(192'(stage_out.src2), 192'(rows[i].exp_src2), {tag, " stage src2"});
			check_value(192'(stage_out.shift_operand), 192'(rows[i].instr[11:0]),
				{tag, " shift_operand"});
			check_value(192'(stage_out.signed_imm), 192'(rows[i].instr[23:0]),
				{tag, " signed_imm"});
		end
	endtask

	// registered results of a row are checked one cycle after it is driven.
	task automatic run_table();
		for (int i = 0; i <= NUM_ROWS; i++) begin
			@(posedge clk);
			if (i < NUM_ROWS)
				drive_row(i);
			else
				drive_idle();
			@(negedge clk);
			if (i < NUM_ROWS)
				check_report(i);
			if (i > 0)
				check_stage(i - 1);
		end
	endtask

	initial begin
		pc     <= '0;
		instr  <= '0;
		status <= '0;
		hazard <= 1'b0;
		flush  <= 1'b0;
		wb     <= NO_WB;
		void'($urandom(SEED));
		foreach (shadow[k])
			shadow[k] = '0;
		build_table();
		wait (rst_n === 1'b1);
		@(negedge clk);
		check_value(192'(stage_out), 192'(0), "stage_out after reset");
		run_table();
		$display("SIMULATION PASSED");
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("SIMULATION FAILED");
		$fatal(1, "watchdog expired, the table did not finish within %0d cycles",
			WATCHDOG_CYCLES);
	end

endmodule

// File: list.f
common/arm_isa_pkg.sv
common/id_stage_pkg.sv
decode/condition_check.sv
decode/control_unit.sv
decode/register_file.sv
decode/id_stage.sv
hdl/id_ex_reg.sv
hdl/id_stage_top.sv
tb/tb_clock.sv
tb/id_stage_tb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing -j 0
TOP      = id_stage_tb
FILELIST = list.f
OBJ_DIR  = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
